//--- filelist.f
srio_init_pkg.sv
pri_timing.sv
chan_write_ctrl.sv
chan_fifo.sv
burst_reader.sv
srio_initial_manage.sv
srio_initial_properties.sv
tb_srio_initial_manage.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, and decide pass or fail from its output
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_srio_initial_manage -f filelist.f \
	--Mdir obj_dir -o sim_tb; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF 'All tests passed!'; then
	exit 0
fi
exit 1

//--- tb_srio_initial_manage.sv
/* testbench for the srio initiator manager; applies a table of write patterns,
   models the link core and checks every captured burst against reference queues */
`timescale 1ns/10ps

module tb_srio_initial_manage;

	localparam int FLUSH_DELAY    = 350;
	localparam int FIFO_DEPTH     = 1024;
	localparam int N_TESTS        = 6;
	localparam int PKT            = srio_init_pkg::PKT_WORDS;
	localparam int DW             = srio_init_pkg::DATA_W;
	localparam int AW             = srio_init_pkg::ADDR_W;
	localparam int MW             = srio_init_pkg::MODE_W;
	localparam int TIMEOUT_CYCLES = N_TESTS * (FLUSH_DELAY + 3 * (PKT + 60) + 100);

	localparam int PAT_IDLE  = 0;	// no writes at all
	localparam int PAT_20M   = 1;	// 32 fir_20m_rdy writes
	localparam int PAT_DDC   = 2;	// 31 writes, pause, one more
	localparam int PAT_BAKER = 3;	// two fir_1m_rdy pulses
	localparam int PAT_FLUSH = 4;	// 20 writes dropped by pri, then 32

	logic          sys_clk;
	logic          rst_n;
	logic          pri;
	logic [MW-1:0] work_mode_ifm;
	logic [MW-1:0] cmd_da;
	logic          fir_20m_rdy;
	logic          fir_1m_rdy;
	logic [DW-1:0] he;
	logic [DW-1:0] fw;
	logic [DW-1:0] fy;
	logic          srio_initial_busy = 1'b0;	// driven by the link core model
	logic          ucfg_normal_trigger;
	logic [7:0]    ucfg_dest_id;
	logic [AW-1:0] ucfg_dest_start_addr;
	logic [DW-1:0] initiator_dout;

	// test table
	string         t_name   [N_TESTS];
	logic [MW-1:0] t_mode   [N_TESTS];
	logic [MW-1:0] t_cmd    [N_TESTS];
	int            t_pat    [N_TESTS];
	logic [2:0]    t_mask   [N_TESTS];	// channels written, bit 0 he
	int            t_bursts [N_TESTS];
	logic [7:0]    t_ids    [N_TESTS][3];	// per channel slot, burst b uses b % 3
	logic [AW-1:0] t_addr   [N_TESTS];

	logic [DW-1:0] ref_he[$];
	logic [DW-1:0] ref_fw[$];
	logic [DW-1:0] ref_fy[$];
	logic [DW-1:0] got_words[$];	// all captured words of the current test
	logic [7:0]    got_ids[$];
	logic [AW-1:0] got_addrs[$];

	logic [31:0] lfsr_state = 32'h7880;
	int          busy_left  = 0;
	int          cap_left   = 0;
	int          cycle_cnt  = 0;
	int          errors     = 0;
	int          checks     = 0;
	int          fails      = 0;
	int          row_errs   = 0;
	string       cur_name   = "reset";

	srio_initial_manage #(
		.FLUSH_DELAY (FLUSH_DELAY),
		.FIFO_DEPTH  (FIFO_DEPTH)
	) srio_initial_manage_inst (
		.sys_clk              (sys_clk),
		.rst_n                (rst_n),
		.pri                  (pri),
		.work_mode_ifm        (work_mode_ifm),
		.cmd_da               (cmd_da),
		.fir_20m_rdy          (fir_20m_rdy),
		.fir_1m_rdy           (fir_1m_rdy),
		.he                   (he),
		.fw                   (fw),
		.fy                   (fy),
		.srio_initial_busy    (srio_initial_busy),
		.ucfg_normal_trigger  (ucfg_normal_trigger),
		.ucfg_dest_id         (ucfg_dest_id),
		.ucfg_dest_start_addr (ucfg_dest_start_addr),
		.initiator_dout       (initiator_dout)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;	// 100 ns period
	end

	// link core: busy for 40 cycles after a trigger, grabs the 32 words behind it
	always @(posedge sys_clk)
	begin
		if (!rst_n)
		begin
			srio_initial_busy <= 1'b0;
			busy_left         <= 0;
			cap_left          <= 0;
		end
		else
		begin
			if (ucfg_normal_trigger)
			begin
				srio_initial_busy <= 1'b1;
				busy_left         <= 40;
				cap_left          <= PKT;
			end
			else if (busy_left == 1)
			begin
				srio_initial_busy <= 1'b0;
				busy_left         <= 0;
			end
			else if (busy_left > 1)
				busy_left <= busy_left - 1;
			if (cap_left != 0)
			begin
				got_words.push_back(initiator_dout);
				if (cap_left == PKT)
				begin
					got_ids.push_back(ucfg_dest_id);	// first word of the packet
					got_addrs.push_back(ucfg_dest_start_addr);
				end
				else
				begin
					assert (ucfg_dest_id == got_ids[got_ids.size() - 1])
					else
					begin
						$display("MISMATCH %0s dest id inside burst: expected %0h, actual %0h",
							cur_name, got_ids[got_ids.size() - 1], ucfg_dest_id);
						errors++;
						row_errs++;
					end
					assert (ucfg_dest_start_addr == got_addrs[got_addrs.size() - 1])
					else
					begin
						$display("MISMATCH %0s dest addr inside burst: expected %0h, actual %0h",
							cur_name, got_addrs[got_addrs.size() - 1], ucfg_dest_start_addr);
						errors++;
						row_errs++;
					end
				end
				cap_left <= cap_left - 1;
			end
		end
	end

	always @(posedge sys_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout in %0s, run did not end within %0d cycles", cur_name,
				TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	// galois lfsr, one step per bit
	function automatic logic [DW-1:0] next_word();
		logic [DW-1:0] w;
		for (int i = 0; i < DW; i++)
		begin
			w[i]       = lfsr_state[0];
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return w;
	endfunction

	function automatic logic [DW-1:0] pop_ref(input int ch);
		logic [DW-1:0] w;
		w = '0;	// empty queue shows up as a zero word
		case (ch)
			0: if (ref_he.size() > 0) w = ref_he.pop_front();
			1: if (ref_fw.size() > 0) w = ref_fw.pop_front();
			default: if (ref_fy.size() > 0) w = ref_fy.pop_front();
		endcase
		return w;
	endfunction

	task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			$display("MISMATCH %0s %0s: expected %0h, actual %0h", cur_name, what, exp, act);
			errors++;
			row_errs++;
		end
	endtask

	task automatic set_row(input int r, input string name, input logic [MW-1:0] mode,
		input logic [MW-1:0] cmd, input int pat, input logic [2:0] mask, input int nb,
		input logic [7:0] id_he, input logic [7:0] id_fw, input logic [7:0] id_fy,
		input logic [AW-1:0] addr);
		t_name[r]   = name;
		t_mode[r]   = mode;
		t_cmd[r]    = cmd;
		t_pat[r]    = pat;
		t_mask[r]   = mask;
		t_bursts[r] = nb;
		t_ids[r][0] = id_he;
		t_ids[r][1] = id_fw;
		t_ids[r][2] = id_fy;
		t_addr[r]   = addr;
	endtask

	// new sample on every channel, only the written ones go to the reference
	task automatic drive_samples(input logic [2:0] mask);
		logic [DW-1:0] w0;
		logic [DW-1:0] w1;
		logic [DW-1:0] w2;
		w0 = next_word();
		w1 = next_word();
		w2 = next_word();
		he <= w0;
		fw <= w1;
		fy <= w2;
		if (mask[0])
			ref_he.push_back(w0);
		if (mask[1])
			ref_fw.push_back(w1);
		if (mask[2])
			ref_fy.push_back(w2);
	endtask

	task automatic write_words(input int n, input logic [2:0] mask);
		for (int i = 0; i < n; i++)
		begin
			@(posedge sys_clk);
			fir_20m_rdy <= 1'b1;
			drive_samples(mask);
		end
		@(posedge sys_clk);
		fir_20m_rdy <= 1'b0;
	endtask

	// words on the 32 edges after the pulse land in the fifos
	task automatic baker_pulse(input logic [2:0] mask);
		@(posedge sys_clk);
		fir_1m_rdy <= 1'b1;
		for (int i = 0; i < PKT; i++)
		begin
			@(posedge sys_clk);
			fir_1m_rdy <= 1'b0;
			drive_samples(mask);
		end
		@(posedge sys_clk);
	endtask

	task automatic pri_pulse();
		@(posedge sys_clk);
		pri <= 1'b1;
		@(posedge sys_clk);
		pri <= 1'b0;
		repeat (FLUSH_DELAY + 2) @(posedge sys_clk);	// fifos flushed by now
	endtask

	task automatic wait_bursts(input int n);
		while (got_ids.size() < n || cap_left != 0 || srio_initial_busy)
			@(posedge sys_clk);
	endtask

	task automatic run_row(input int r);
		int            b;
		int            k;
		int            ch;
		logic [DW-1:0] exp_w;
		cur_name = t_name[r];
		row_errs = 0;
		ref_he.delete();
		ref_fw.delete();
		ref_fy.delete();
		got_words.delete();
		got_ids.delete();
		got_addrs.delete();
		@(posedge sys_clk);
		work_mode_ifm <= t_mode[r];
		cmd_da        <= t_cmd[r];
		pri_pulse();
		case (t_pat[r])
			PAT_IDLE: repeat (PKT + 60) @(posedge sys_clk);
			PAT_20M: write_words(PKT, t_mask[r]);
			PAT_DDC:
			begin
				write_words(PKT - 1, t_mask[r]);
				repeat (60) @(posedge sys_clk);
				check_val("bursts at 31 words", 64'd0, 64'(got_ids.size()));
				write_words(1, t_mask[r]);
			end
			PAT_BAKER:
			begin
				baker_pulse(t_mask[r]);
				wait_bursts(3);
				baker_pulse(t_mask[r]);
			end
			default:
			begin
				write_words(20, t_mask[r]);
				pri_pulse();	// these 20 words are dropped
				ref_he.delete();
				ref_fw.delete();
				ref_fy.delete();
				write_words(PKT, t_mask[r]);
			end
		endcase
		wait_bursts(t_bursts[r]);
		repeat (10) @(posedge sys_clk);	// room for a stray extra burst
		check_val("burst count", 64'(t_bursts[r]), 64'(got_ids.size()));
		for (b = 0; b < t_bursts[r] && b < got_ids.size(); b++)
		begin
			ch = (t_cmd[r] != 8'h00) ? int'(t_cmd[r]) - 4 : b % 3;	// ddc 04..06 map he..fy
			check_val($sformatf("burst %0d dest id", b), 64'(t_ids[r][b % 3]), 64'(got_ids[b]));
			check_val($sformatf("burst %0d dest addr", b), 64'(t_addr[r]), 64'(got_addrs[b]));
			for (k = 0; k < PKT; k++)
			begin
				exp_w = pop_ref(ch);
				check_val($sformatf("burst %0d word %0d", b, k), exp_w, got_words[b * PKT + k]);
			end
		end
		if (t_pat[r] == PAT_IDLE)
		begin
			check_val("initiator_dout", 64'd0, initiator_dout);
			check_val("dest id", 64'd0, 64'(ucfg_dest_id));
		end
		if (row_errs != 0)
			fails++;
		$display("test %0d %0s: %0s, %0d bursts seen", r, t_name[r],
			(row_errs == 0) ? "ok" : "FAILED", got_ids.size());
	endtask

	initial
	begin
		rst_n         = 1'b0;
		pri           = 1'b0;
		work_mode_ifm = '0;
		cmd_da        = '0;
		fir_20m_rdy   = 1'b0;
		fir_1m_rdy    = 1'b0;
		he            = '0;
		fw            = '0;
		fy            = '0;
		set_row(0, "reset_idle", 8'd0, srio_init_pkg::CMD_NONE, PAT_IDLE, 3'b000, 0,
			8'h00, 8'h00, 8'h00, '0);
		set_row(1, "normal_mode", 8'd0, srio_init_pkg::CMD_NONE, PAT_20M, 3'b111, 3,
			srio_init_pkg::ID_FPGA1, srio_init_pkg::ID_FPGA2, srio_init_pkg::ID_FPGA3,
			srio_init_pkg::ADDR_DEFAULT);
		set_row(2, "recog_mode", 8'd5, srio_init_pkg::CMD_NONE, PAT_20M, 3'b111, 3,
			srio_init_pkg::ID_RECOG, srio_init_pkg::ID_FPGA2, srio_init_pkg::ID_FPGA3,
			srio_init_pkg::ADDR_DEFAULT);
		set_row(3, "ddc_fw_cmd", 8'd0, srio_init_pkg::CMD_DDC_FW, PAT_DDC, 3'b010, 1,
			srio_init_pkg::ID_BOARD, srio_init_pkg::ID_BOARD, srio_init_pkg::ID_BOARD,
			srio_init_pkg::ADDR_DDC);
		set_row(4, "baker_mode", 8'd1, srio_init_pkg::CMD_NONE, PAT_BAKER, 3'b111, 6,
			srio_init_pkg::ID_FPGA1, srio_init_pkg::ID_FPGA2, srio_init_pkg::ID_FPGA3,
			srio_init_pkg::ADDR_DEFAULT);
		set_row(5, "pri_flush", 8'd0, srio_init_pkg::CMD_NONE, PAT_FLUSH, 3'b111, 3,
			srio_init_pkg::ID_FPGA1, srio_init_pkg::ID_FPGA2, srio_init_pkg::ID_FPGA3,
			srio_init_pkg::ADDR_DEFAULT);
		repeat (2) @(posedge sys_clk);
		rst_n <= 1'b1;
		for (int r = 0; r < N_TESTS; r++)
			run_row(r);
		$display("%0d tests, %0d failed, %0d of %0d checks failed", N_TESTS, fails,
			errors, checks);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- srio_initial_properties.sv
/* concurrent checks on the fifo read side, bound into every burst_reader */
`timescale 1ns/10ps

module srio_initial_properties (
	input logic                                 sys_clk,
	input logic                                 rst_n,
	input logic                                 srio_initial_busy,
	input logic                                 ucfg_normal_trigger,
	input logic [2:0]                           rd_en,
	input logic [2:0][srio_init_pkg::CNT_W-1:0] word_count
);

	localparam logic [6:0] BURST = 7'(srio_init_pkg::PKT_WORDS);

	logic [6:0] run_len;	// cycles rd_en has been high so far

	always @(posedge sys_clk)
	begin
		if (!rst_n)
			run_len <= 7'd0;
		else if (|rd_en)
			run_len <= run_len + 7'd1;
		else
			run_len <= 7'd0;
	end

	rd_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n) $onehot0(rd_en))
		else $error("more than one fifo read enable high at once");

	burst_not_long: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(|rd_en) |-> (run_len < BURST))
		else $error("read burst longer than one packet");

	// burst ends exactly at 32
	burst_not_short: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$fell(|rd_en) |-> (run_len == BURST))
		else $error("read burst ended before a full packet");

	trig_idle_link: assert property (@(posedge sys_clk) disable iff (!rst_n)
		ucfg_normal_trigger |-> !srio_initial_busy)
		else $error("trigger issued while the link core was busy");

	no_empty_read: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(rd_en & {word_count[2] == '0, word_count[1] == '0, word_count[0] == '0}) == 3'b000)
		else $error("fifo read while its word count was zero");

endmodule

bind burst_reader srio_initial_properties props_inst (
	.sys_clk             (sys_clk),
	.rst_n               (rst_n),
	.srio_initial_busy   (srio_initial_busy),
	.ucfg_normal_trigger (ucfg_normal_trigger),
	.rd_en               (rd_en),
	.word_count          (word_count)
);

//--- srio_initial_manage.sv
/* top of the srio initiator manager; collects he, fw and fy samples into
   three fifos and feeds 32 word write bursts to the link core */
`timescale 1ns/10ps

module srio_initial_manage #(
	parameter int FLUSH_DELAY = 350,	// pri edge to fifo flush
	parameter int FIFO_DEPTH  = 1024
) (
	input  logic                             sys_clk,
	input  logic                             rst_n,
	input  logic                             pri,
	input  logic [srio_init_pkg::MODE_W-1:0] work_mode_ifm,
	input  logic [srio_init_pkg::MODE_W-1:0] cmd_da,
	input  logic                             fir_20m_rdy,
	input  logic                             fir_1m_rdy,
	input  logic [srio_init_pkg::DATA_W-1:0] he,
	input  logic [srio_init_pkg::DATA_W-1:0] fw,
	input  logic [srio_init_pkg::DATA_W-1:0] fy,
	input  logic                             srio_initial_busy,
	output logic                             ucfg_normal_trigger,
	output logic [7:0]                       ucfg_dest_id,
	output logic [srio_init_pkg::ADDR_W-1:0] ucfg_dest_start_addr,
	output logic [srio_init_pkg::DATA_W-1:0] initiator_dout
);

	logic [srio_init_pkg::MODE_W-1:0]      work_mode;
	logic                                  flush;
	logic [2:0]                            wr_en;	// index 0 he, 1 fw, 2 fy
	logic [2:0][srio_init_pkg::DATA_W-1:0] wr_data;
	logic [2:0]                            rd_en;
	logic [2:0][srio_init_pkg::DATA_W-1:0] rd_data;
	logic [2:0][srio_init_pkg::CNT_W-1:0]  word_count;

	pri_timing #(
		.FLUSH_DELAY (FLUSH_DELAY)
	) pri_timing_inst (
		.sys_clk       (sys_clk),
		.rst_n         (rst_n),
		.pri           (pri),
		.work_mode_ifm (work_mode_ifm),
		.work_mode     (work_mode),
		.flush         (flush)
	);

	chan_write_ctrl chan_write_ctrl_inst (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.flush       (flush),
		.cmd_da      (cmd_da),
		.work_mode   (work_mode),
		.fir_20m_rdy (fir_20m_rdy),
		.fir_1m_rdy  (fir_1m_rdy),
		.he          (he),
		.fw          (fw),
		.fy          (fy),
		.wr_en       (wr_en),
		.wr_data     (wr_data)
	);

	chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_he (
		.sys_clk (sys_clk), .rst_n (rst_n), .flush (flush),
		.wr_en (wr_en[0]), .wr_data (wr_data[0]),
		.rd_en (rd_en[0]), .rd_data (rd_data[0]), .word_count (word_count[0])
	);

	chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_fw (
		.sys_clk (sys_clk), .rst_n (rst_n), .flush (flush),
		.wr_en (wr_en[1]), .wr_data (wr_data[1]),
		.rd_en (rd_en[1]), .rd_data (rd_data[1]), .word_count (word_count[1])
	);

	chan_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_fy (
		.sys_clk (sys_clk), .rst_n (rst_n), .flush (flush),
		.wr_en (wr_en[2]), .wr_data (wr_data[2]),
		.rd_en (rd_en[2]), .rd_data (rd_data[2]), .word_count (word_count[2])
	);

	burst_reader burst_reader_inst (
		.sys_clk              (sys_clk),
		.rst_n                (rst_n),
		.flush                (flush),
		.cmd_da               (cmd_da),
		.work_mode            (work_mode),
		.srio_initial_busy    (srio_initial_busy),
		.word_count           (word_count),
		.rd_data              (rd_data),
		.rd_en                (rd_en),
		.ucfg_normal_trigger  (ucfg_normal_trigger),
		.ucfg_dest_id         (ucfg_dest_id),
		.ucfg_dest_start_addr (ucfg_dest_start_addr),
		.initiator_dout       (initiator_dout)
	);

endmodule

//--- burst_reader.sv
/* read side of the three fifos; rotates the channel on busy falling edges,
   fires one 32 word burst per trigger edge and sets the packet addressing */
`timescale 1ns/10ps

module burst_reader (
	input  logic                                  sys_clk,
	input  logic                                  rst_n,
	input  logic                                  flush,
	input  logic [srio_init_pkg::MODE_W-1:0]      cmd_da,
	input  logic [srio_init_pkg::MODE_W-1:0]      work_mode,
	input  logic                                  srio_initial_busy,
	input  logic [2:0][srio_init_pkg::CNT_W-1:0]  word_count,
	input  logic [2:0][srio_init_pkg::DATA_W-1:0] rd_data,
	output logic [2:0]                            rd_en,
	output logic                                  ucfg_normal_trigger,
	output logic [7:0]                            ucfg_dest_id,
	output logic [srio_init_pkg::ADDR_W-1:0]      ucfg_dest_start_addr,
	output logic [srio_init_pkg::DATA_W-1:0]      initiator_dout
);

	localparam int BW = $clog2(srio_init_pkg::PKT_WORDS);
	localparam logic [srio_init_pkg::CNT_W-1:0] PKT_CNT =
		srio_init_pkg::CNT_W'(srio_init_pkg::PKT_WORDS);

	srio_init_pkg::chan_t sel;	// channel to send next
	srio_init_pkg::chan_t sel_nxt;
	srio_init_pkg::chan_t cmd_chan;

	logic                              busy_d;
	logic                              busy_fall;
	logic [srio_init_pkg::CNT_W-1:0]   sel_count;
	logic                              trig;	// packet ready and link idle
	logic                              trig_d;
	logic                              trig_start;
	logic [BW-1:0]                     rd_cnt;	// words issued in this burst
	logic                              burst_act;
	logic [2:0]                        rd_en_d;	// steers the output mux
	logic [7:0]                        id_nxt;
	logic [srio_init_pkg::ADDR_W-1:0]  addr_nxt;

	assign busy_fall = busy_d & ~srio_initial_busy;

	always_comb
	begin
		case (sel)
			srio_init_pkg::CH_FW: sel_count = word_count[1];
			srio_init_pkg::CH_FY: sel_count = word_count[2];
			default:              sel_count = word_count[0];
		endcase
	end

	// he -> fw -> fy -> he
	always_comb
	begin
		case (sel)
			srio_init_pkg::CH_HE: sel_nxt = srio_init_pkg::CH_FW;
			srio_init_pkg::CH_FW: sel_nxt = srio_init_pkg::CH_FY;
			default:              sel_nxt = srio_init_pkg::CH_HE;
		endcase
		case (cmd_da)
			srio_init_pkg::CMD_DDC_FW: cmd_chan = srio_init_pkg::CH_FW;
			srio_init_pkg::CMD_DDC_FY: cmd_chan = srio_init_pkg::CH_FY;
			default:                   cmd_chan = srio_init_pkg::CH_HE;
		endcase
	end

	always_ff @(posedge sys_clk)
	begin
		if (!rst_n)
		begin
			busy_d <= 1'b0;
			sel    <= srio_init_pkg::CH_HE;
		end
		else
		begin
			busy_d <= srio_initial_busy;
			if (cmd_da != srio_init_pkg::CMD_NONE)
				sel <= cmd_chan;	// directed command pins the channel
			else if (flush)
				sel <= srio_init_pkg::CH_HE;
			else if (busy_fall)
				sel <= sel_nxt;
		end
	end

	assign trig       = (sel_count >= PKT_CNT) && !srio_initial_busy;
	assign trig_start = trig & ~trig_d & (rd_cnt == '0);	// no retrigger mid burst
	assign burst_act  = trig_start | (rd_cnt != '0);

	// rd_en high from the edge cycle for 32 cycles
	always_comb
	begin
		rd_en[0] = burst_act && (sel == srio_init_pkg::CH_HE);
		rd_en[1] = burst_act && (sel == srio_init_pkg::CH_FW);
		rd_en[2] = burst_act && (sel == srio_init_pkg::CH_FY);
	end

	always_ff @(posedge sys_clk)
	begin
		if (!rst_n)
		begin
			trig_d              <= 1'b0;
			rd_cnt              <= '0;
			rd_en_d             <= 3'b000;
			ucfg_normal_trigger <= 1'b0;
		end
		else
		begin
			trig_d              <= trig;
			rd_en_d             <= rd_en;
			ucfg_normal_trigger <= trig_start;	// one cycle after the edge
			if (flush)
				rd_cnt <= '0;
			else if (rd_cnt == BW'(srio_init_pkg::PKT_WORDS - 1))
				rd_cnt <= '0;
			else if (burst_act)
				rd_cnt <= rd_cnt + 1'b1;
		end
	end

	// destination for the packet about to go out
	always_comb
	begin
		addr_nxt = srio_init_pkg::ADDR_DEFAULT;
		if (cmd_da != srio_init_pkg::CMD_NONE)
		begin
			id_nxt = srio_init_pkg::ID_BOARD;
			if (cmd_da >= srio_init_pkg::CMD_DDC_HE && cmd_da <= srio_init_pkg::CMD_DDC_FY)
				addr_nxt = srio_init_pkg::ADDR_DDC;
		end
		else
		begin
			case (sel)
				srio_init_pkg::CH_FW: id_nxt = srio_init_pkg::ID_FPGA2;
				srio_init_pkg::CH_FY: id_nxt = srio_init_pkg::ID_FPGA3;
				default:
				begin
					if (srio_init_pkg::is_recog(work_mode))
						id_nxt = srio_init_pkg::ID_RECOG;
					else
						id_nxt = srio_init_pkg::ID_FPGA1;
				end
			endcase
		end
	end

	// latched at the trigger edge so they hold through the burst
	always_ff @(posedge sys_clk)
	begin
		if (!rst_n)
		begin
			ucfg_dest_id         <= 8'h00;
			ucfg_dest_start_addr <= '0;
		end
		else if (trig_start)
		begin
			ucfg_dest_id         <= id_nxt;
			ucfg_dest_start_addr <= addr_nxt;
		end
	end

	// fifo data lands one cycle after rd_en; hold the last word between bursts
	always_ff @(posedge sys_clk)
	begin
		if (!rst_n)
			initiator_dout <= '0;
		else
		begin
			case (rd_en_d)
				3'b001:  initiator_dout <= rd_data[0];
				3'b010:  initiator_dout <= rd_data[1];
				3'b100:  initiator_dout <= rd_data[2];
				default: initiator_dout <= initiator_dout;
			endcase
		end
	end

endmodule

//--- chan_fifo.sv
/* single clock circular fifo per channel with registered read data,
   a read side word count and a synchronous flush */
`timescale 1ns/10ps

module chan_fifo #(
	parameter int FIFO_DEPTH = 1024
) (
	input  logic                             sys_clk,
	input  logic                             rst_n,
	input  logic                             flush,
	input  logic                             wr_en,
	input  logic [srio_init_pkg::DATA_W-1:0] wr_data,
	input  logic                             rd_en,
	output logic [srio_init_pkg::DATA_W-1:0] rd_data,
	output logic [srio_init_pkg::CNT_W-1:0]  word_count
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [srio_init_pkg::CNT_W-1:0] CNT_MAX = '1;

	logic [srio_init_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   fill;	// words held, 0..FIFO_DEPTH
	logic             full;
	logic             empty;
	logic             do_wr;
	logic             do_rd;

	// wrap at FIFO_DEPTH so any depth works
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full  = (fill == (PTR_W + 1)'(FIFO_DEPTH));
	assign empty = (fill == '0);
	assign do_wr = wr_en & ~full;	// drop when full
	assign do_rd = rd_en & ~empty;	// ignore when empty

	// count clamps at the port width
	assign word_count = (fill > CNT_MAX) ? CNT_MAX : srio_init_pkg::CNT_W'(fill);

	always_ff @(posedge sys_clk)
	begin
		if (!rst_n || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_wr, do_rd})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;	// both or neither
			endcase
		end
	end

	// storage and read port
	always_ff @(posedge sys_clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr];	// valid the cycle after rd_en
	end

endmodule

//--- chan_write_ctrl.sv
/* fifo write side for the he, fw and fy channels; picks normal, baker or
   directed ddc writes and registers the enables with the sample words */
`timescale 1ns/10ps

module chan_write_ctrl (
	input  logic                                  sys_clk,
	input  logic                                  rst_n,
	input  logic                                  flush,
	input  logic [srio_init_pkg::MODE_W-1:0]      cmd_da,
	input  logic [srio_init_pkg::MODE_W-1:0]      work_mode,
	input  logic                                  fir_20m_rdy,
	input  logic                                  fir_1m_rdy,
	input  logic [srio_init_pkg::DATA_W-1:0]      he,
	input  logic [srio_init_pkg::DATA_W-1:0]      fw,
	input  logic [srio_init_pkg::DATA_W-1:0]      fy,
	output logic [2:0]                            wr_en,
	output logic [2:0][srio_init_pkg::DATA_W-1:0] wr_data
);

	localparam logic [5:0] BURST_LEN = 6'(srio_init_pkg::PKT_WORDS);

	logic [5:0] baker_cnt;	// 0 idle, 1..32 inside the baker window
	logic       baker_act;
	logic [2:0] wr_en_nxt;

	assign baker_act = (baker_cnt != 6'd0);

	// baker window opens on fir_1m_rdy and lasts 32 cycles
	always_ff @(posedge sys_clk)
	begin
		if (!rst_n)
			baker_cnt <= 6'd0;
		else if (flush)
			baker_cnt <= 6'd0;
		else if (baker_cnt == BURST_LEN)
			baker_cnt <= 6'd0;
		else if (fir_1m_rdy)
			baker_cnt <= 6'd1;
		else if (baker_act)
			baker_cnt <= baker_cnt + 1'b1;
	end

	// bit 0 he, bit 1 fw, bit 2 fy
	always_comb
	begin
		case (cmd_da)
			srio_init_pkg::CMD_DDC_HE: wr_en_nxt = {2'b00, fir_20m_rdy};
			srio_init_pkg::CMD_DDC_FW: wr_en_nxt = {1'b0, fir_20m_rdy, 1'b0};
			srio_init_pkg::CMD_DDC_FY: wr_en_nxt = {fir_20m_rdy, 2'b00};
			default:
			begin
				if (srio_init_pkg::is_baker(work_mode))
					wr_en_nxt = {3{baker_act}};	// all three for the window
				else
					wr_en_nxt = {3{fir_20m_rdy}};	// normal mode
			end
		endcase
	end

	always_ff @(posedge sys_clk)
	begin
		if (!rst_n)
			wr_en <= 3'b000;
		else
			wr_en <= wr_en_nxt;
	end

	// samples ride one cycle behind, aligned with wr_en
	always_ff @(posedge sys_clk)
	begin
		wr_data[0] <= he;
		wr_data[1] <= fw;
		wr_data[2] <= fy;
	end

endmodule

//--- pri_timing.sv
/* pri edge detect, work mode capture while pri is high, and the delayed
   flush pulse that drops late fir output of the previous pulse */
`timescale 1ns/10ps

module pri_timing #(
	parameter int FLUSH_DELAY = 350
) (
	input  logic                             sys_clk,
	input  logic                             rst_n,
	input  logic                             pri,
	input  logic [srio_init_pkg::MODE_W-1:0] work_mode_ifm,
	output logic [srio_init_pkg::MODE_W-1:0] work_mode,
	output logic                             flush
);

	localparam int CW = $clog2(FLUSH_DELAY + 1);

	logic          pri_d;	// pri one cycle late
	logic          pri_rise;
	logic [CW-1:0] dly_cnt;	// cycles since last pri edge, saturating

	assign pri_rise = pri & ~pri_d;

	always_ff @(posedge sys_clk)
	begin
		if (!rst_n)
		begin
			pri_d     <= 1'b0;
			work_mode <= '0;
		end
		else
		begin
			pri_d <= pri;
			if (pri)
				work_mode <= work_mode_ifm;	// only changes inside pri
		end
	end

	// dly_cnt reads k on the k-th cycle after the edge
	always_ff @(posedge sys_clk)
	begin
		if (!rst_n)
		begin
			dly_cnt <= CW'(FLUSH_DELAY);	// parked, no flush out of reset
			flush   <= 1'b0;
		end
		else
		begin
			if (pri_rise)
				dly_cnt <= CW'(1);
			else if (dly_cnt < CW'(FLUSH_DELAY))
				dly_cnt <= dly_cnt + 1'b1;

			// one cycle pulse exactly FLUSH_DELAY after the edge
			if (pri_rise)
				flush <= (FLUSH_DELAY == 1);
			else
				flush <= (dly_cnt == CW'(FLUSH_DELAY - 1));
		end
	end

endmodule

//--- srio_init_pkg.sv
/* shared widths, packet constants, command codes and destination table
   for the srio initiator manager, referenced by scoped name */
package srio_init_pkg;

	localparam int DATA_W    = 64;	// one packed iq sample word
	localparam int PKT_WORDS = 32;	// words per write burst
	localparam int CNT_W     = 10;	// fifo word count
	localparam int ADDR_W    = 34;	// srio dest address
	localparam int MODE_W    = 8;	// work mode and cmd_da

	// channel select, also the index into the fifo bundles
	typedef enum logic [1:0] {
		CH_HE = 2'd0,
		CH_FW = 2'd1,
		CH_FY = 2'd2
	} chan_t;

	// interface board commands on cmd_da
	localparam logic [MODE_W-1:0] CMD_NONE   = 8'h00;
	localparam logic [MODE_W-1:0] CMD_DDC_HE = 8'h04;	// sum channel only
	localparam logic [MODE_W-1:0] CMD_DDC_FW = 8'h05;	// azimuth diff only
	localparam logic [MODE_W-1:0] CMD_DDC_FY = 8'h06;	// elevation diff only

	// destination ids
	localparam logic [7:0] ID_BOARD = 8'h08;	// interface board fpga
	localparam logic [7:0] ID_FPGA1 = 8'h0e;
	localparam logic [7:0] ID_FPGA2 = 8'h10;
	localparam logic [7:0] ID_FPGA3 = 8'h0f;
	localparam logic [7:0] ID_RECOG = 8'h11;	// recognition fpga

	localparam logic [ADDR_W-1:0] ADDR_DEFAULT = 34'h0_0000_0100;
	localparam logic [ADDR_W-1:0] ADDR_DDC     = 34'h0_0200_0000;

	// baker modes take 32 words per fir_1m_rdy
	function automatic logic is_baker(input logic [MODE_W-1:0] mode);
		return (mode == 8'd1) || (mode == 8'd3);
	endfunction

	// recognition modes route he to the recog fpga
	function automatic logic is_recog(input logic [MODE_W-1:0] mode);
		return (mode == 8'd5) || (mode == 8'd6) || (mode == 8'd7);
	endfunction

endpackage
